/* Bender.yml */
package:
  name: psr_unit

export_include_dirs:
  - hw

sources:
  - files:
      - hw/psr_arch_pkg.sv
      - hw/psr_ctrl_pkg.sv
      - hw/psr_write_unit.sv
      - hw/spsr_slot.sv
      - hw/psr_read_mux.sv
      - hw/psr_unit.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/psr_unit_chk.sv
      - verif/psr_scoreboard.sv
      - verif/psr_unit_tb.sv

/* hw/psr_arch_pkg.sv */
`include "psr_params.svh"

package psr_arch_pkg;

	typedef logic [`PSR_WORD_W-1:0] word;

	typedef enum logic [4:0] {
		MODE_USR = 5'b10000,
		MODE_FIQ = 5'b10001,
		MODE_IRQ = 5'b10010,
		MODE_SVC = 5'b10011,
		MODE_ABT = 5'b10111,
		MODE_UND = 5'b11011,
		MODE_SYS = 5'b11111
	} psr_mode;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} psr_flags;

	typedef struct packed {
		logic i;
		logic f;
	} psr_intmask;

	// the part of a status register this core actually keeps
	typedef struct packed {
		psr_flags   flags;
		psr_intmask mask;
		psr_mode    mode;
	} psr_state;

	typedef struct packed {
		psr_flags    nzcv;     // bits 31..28
		logic [18:0] reserved;
		logic        a;        // always reads as one, aborts are never imprecise here
		psr_intmask  if_;
		logic        t;
		psr_mode     m;
	} psr_word;

	// slot order of the banked SPSRs
	localparam psr_mode bank_modes [`PSR_BANKS] = '{MODE_SVC, MODE_ABT, MODE_UND, MODE_IRQ, MODE_FIQ};

	function automatic logic psr_mode_valid(logic [4:0] m);
		case (m)
			MODE_USR, MODE_FIQ, MODE_IRQ, MODE_SVC,
			MODE_ABT, MODE_UND, MODE_SYS: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// USR and SYS share registers and have no SPSR of their own
	function automatic logic psr_mode_banked(logic [4:0] m);
		case (m)
			MODE_FIQ, MODE_IRQ, MODE_SVC, MODE_ABT, MODE_UND: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

endpackage

/* hw/psr_ctrl_pkg.sv */
package psr_ctrl_pkg;

	// one operation per cycle, presented as a single-cycle strobe
	typedef enum logic [2:0] {
		OP_NONE  = 3'd0,
		OP_FLAGS = 3'd1, // ALU flag update
		OP_MSR   = 3'd2,
		OP_EXC   = 3'd3, // exception entry
		OP_RET   = 3'd4  // exception return, CPSR from current SPSR
	} psr_op;

	// which fields of a status write are allowed through
	typedef struct packed {
		logic flags;   // nzcv
		logic control; // interrupt mask and mode
	} psr_fields;

	localparam psr_fields FIELDS_ALL = '{flags: 1'b1, control: 1'b1};

endpackage

/* hw/psr_params.svh */
`ifndef PSR_PARAMS_SVH
`define PSR_PARAMS_SVH

// width of a packed status word as seen by MRS and MSR
`define PSR_WORD_W 32

// one saved status register per exception mode
`define PSR_BANKS 5

// CPSR after reset: supervisor mode with both interrupt sources masked
`define PSR_RST_FLAGS 4'b0000
`define PSR_RST_MASK  2'b11
`define PSR_RST_MODE  5'b10011

`endif

/* hw/psr_read_mux.sv */
`timescale 1ns/100ps
`include "psr_params.svh"

module psr_read_mux
	import psr_arch_pkg::*;
(
	input  psr_state cpsr,
	input  logic     saved,
	input  psr_state spsr_bank [`PSR_BANKS],

	output psr_state cur_spsr,
	output word      psr_rd
);

	psr_word  rd_word;
	psr_state rd_state;

	// USR and SYS match no slot and read back as zero
	always_comb begin
		cur_spsr = '0;
		for (int k = 0; k < `PSR_BANKS; k++) begin
			if (cpsr.mode == bank_modes[k])
				cur_spsr = spsr_bank[k];
		end
	end

	assign rd_state = saved ? cur_spsr : cpsr;

	always_comb begin
		rd_word      = '0;
		rd_word.a    = 1'b1;
		rd_word.nzcv = rd_state.flags;
		rd_word.if_  = rd_state.mask;
		rd_word.m    = rd_state.mode;
	end

	assign psr_rd = rd_word;

endmodule

/* hw/psr_unit.sv */
`timescale 1ns/100ps
`include "psr_params.svh"

module psr_unit
	import psr_arch_pkg::*, psr_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  psr_op      op,
	input  logic       saved,
	input  logic       wr_flags,
	input  logic       wr_control,
	input  logic       alu_v_valid,
	input  psr_flags   alu_flags,
	input  word        psr_wr,
	input  psr_mode    exc_mode,

	output psr_flags   flags,
	output psr_intmask mask,
	output psr_mode    mode,
	output word        psr_rd
);

	psr_state cpsr;
	psr_state cur_spsr;
	psr_state load_state;
	psr_mode  load_mode;
	logic     load_en;
	psr_state spsr_bank [`PSR_BANKS];

	assign flags = cpsr.flags;
	assign mask  = cpsr.mask;
	assign mode  = cpsr.mode;

	psr_write_unit write_unit_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.op          (op),
		.saved       (saved),
		.wr_flags    (wr_flags),
		.wr_control  (wr_control),
		.alu_v_valid (alu_v_valid),
		.alu_flags   (alu_flags),
		.psr_wr      (psr_wr),
		.exc_mode    (exc_mode),
		.cur_spsr    (cur_spsr),
		.cpsr        (cpsr),
		.load_en     (load_en),
		.load_mode   (load_mode),
		.load_state  (load_state)
	);

	// one slot per banked mode, in bank_modes order
	for (genvar g = 0; g < `PSR_BANKS; g++) begin : g_slot
		spsr_slot #(
			.BANK_MODE (bank_modes[g])
		) slot_i (
			.clk        (clk),
			.rst_n      (rst_n),
			.load_en    (load_en),
			.load_mode  (load_mode),
			.load_state (load_state),
			.spsr       (spsr_bank[g])
		);
	end

	psr_read_mux read_mux_i (
		.cpsr      (cpsr),
		.saved     (saved),
		.spsr_bank (spsr_bank),
		.cur_spsr  (cur_spsr),
		.psr_rd    (psr_rd)
	);

endmodule

/* hw/psr_write_unit.sv */
`timescale 1ns/100ps
`include "psr_params.svh"

module psr_write_unit
	import psr_arch_pkg::*, psr_ctrl_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  psr_op    op,
	input  logic     saved,
	input  logic     wr_flags,
	input  logic     wr_control,
	input  logic     alu_v_valid,
	input  psr_flags alu_flags,
	input  word      psr_wr,
	input  psr_mode  exc_mode,
	input  psr_state cur_spsr,

	output psr_state cpsr,
	output logic     load_en,
	output psr_mode  load_mode,
	output psr_state load_state
);

	psr_word   wr_word;
	psr_state  wr_state;
	psr_state  msr_clean;
	psr_state  ret_clean;
	psr_state  cpsr_next;
	psr_flags  next_flags;
	psr_fields msr_sel;

	// the rules are applied in order, later ones override earlier ones
	function automatic psr_state sanitize(psr_state wr, psr_fields sel, psr_state cur);
		psr_state clean;

		clean = wr;
		if (!psr_mode_valid(wr.mode))
			clean.mode = cur.mode;

		if (!sel.flags)
			clean.flags = cur.flags;

		if (!sel.control) begin
			clean.mask = cur.mask;
			clean.mode = cur.mode;
		end

		// user code cannot unmask interrupts or leave user mode
		if (cur.mode == MODE_USR) begin
			clean.mask = cur.mask;
			clean.mode = MODE_USR;
		end

		return clean;
	endfunction

	assign wr_word = psr_wr;

	assign wr_state.flags = wr_word.nzcv;
	assign wr_state.mask  = wr_word.if_;
	assign wr_state.mode  = wr_word.m;

	assign msr_sel.flags   = wr_flags;
	assign msr_sel.control = wr_control;

	assign msr_clean = sanitize(wr_state, msr_sel, cpsr);
	assign ret_clean = sanitize(cur_spsr, FIELDS_ALL, cpsr); // a zeroed slot has an invalid mode

	always_comb begin
		next_flags = alu_flags;
		if (!alu_v_valid)
			next_flags.v = cpsr.flags.v; // ops that leave overflow alone

		cpsr_next  = cpsr;
		load_en    = 1'b0;
		load_mode  = cpsr.mode;
		load_state = msr_clean;

		unique case (op)
			OP_FLAGS:
				cpsr_next.flags = next_flags;

			OP_MSR:
				if (!saved)
					cpsr_next = msr_clean;
				else
					load_en = psr_mode_banked(cpsr.mode); // no SPSR in USR or SYS

			OP_EXC:
				if (psr_mode_banked(exc_mode)) begin
					load_en    = 1'b1;
					load_mode  = exc_mode;
					load_state = cpsr;

					cpsr_next.mode   = exc_mode;
					cpsr_next.mask.i = 1'b1;
					if (exc_mode == MODE_FIQ)
						cpsr_next.mask.f = 1'b1;
				end

			OP_RET:
				if (psr_mode_banked(cpsr.mode))
					cpsr_next = ret_clean;

			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cpsr.flags <= `PSR_RST_FLAGS;
			cpsr.mask  <= `PSR_RST_MASK;
			cpsr.mode  <= psr_mode'(`PSR_RST_MODE);
		end else begin
			cpsr <= cpsr_next;
		end
	end

endmodule

/* hw/spsr_slot.sv */
`timescale 1ns/100ps

module spsr_slot
	import psr_arch_pkg::*;
#(
	parameter psr_mode BANK_MODE = MODE_SVC
)
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     load_en,
	input  psr_mode  load_mode,
	input  psr_state load_state,

	output psr_state spsr
);

	logic hit;

	// every slot sees the same load, only the one for its own mode takes it
	assign hit = load_en && (load_mode == BANK_MODE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			spsr <= '0;
		else if (hit)
			spsr <= load_state;
	end

endmodule

/* verif/psr_scoreboard.sv */
`timescale 1ns/100ps
`include "psr_params.svh"

module psr_scoreboard
	import psr_arch_pkg::*, psr_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  psr_op      op,
	input  logic       saved,
	input  logic       wr_flags,
	input  logic       wr_control,
	input  logic       alu_v_valid,
	input  psr_flags   alu_flags,
	input  word        psr_wr,
	input  psr_mode    exc_mode,
	input  psr_flags   flags,
	input  psr_intmask mask,
	input  psr_mode    mode,
	input  word        psr_rd,

	output int         tests_run,
	output int         tests_failed
);

	psr_state model_cpsr;
	psr_state model_spsr [`PSR_BANKS];
	int       test_errors;

	initial begin
		tests_run = 0;
		tests_failed = 0;
		test_errors = 0;
	end

	// slot order is SVC, ABT, UND, IRQ, FIQ, with no slot for USR and SYS
	function automatic int slot_of(logic [4:0] m);
		case (m)
			MODE_SVC: return 0;
			MODE_ABT: return 1;
			MODE_UND: return 2;
			MODE_IRQ: return 3;
			MODE_FIQ: return 4;
			default:  return -1;
		endcase
	endfunction

	function automatic psr_state apply_write(psr_state w, logic fl_en, logic ctl_en, psr_state cur);
		psr_state r;
		r = cur;
		if (fl_en)
			r.flags = w.flags;
		if (ctl_en && cur.mode != MODE_USR) begin
			r.mask = w.mask;
			if (slot_of(w.mode) >= 0 || w.mode == MODE_USR || w.mode == MODE_SYS)
				r.mode = w.mode;
		end
		return r;
	endfunction

	task automatic step_model();
		psr_state w;
		psr_flags nf;
		int       k;
		w.flags = psr_flags'(psr_wr[31:28]);
		w.mask = psr_intmask'(psr_wr[7:6]);
		w.mode = psr_mode'(psr_wr[4:0]);
		case (op)
			OP_FLAGS: begin
				nf = alu_flags;
				if (!alu_v_valid)
					nf.v = model_cpsr.flags.v;
				model_cpsr.flags = nf;
			end
			OP_MSR: begin
				k = slot_of(model_cpsr.mode);
				if (!saved)
					model_cpsr = apply_write(w, wr_flags, wr_control, model_cpsr);
				else if (k >= 0)
					model_spsr[k] = apply_write(w, wr_flags, wr_control, model_cpsr);
			end
			OP_EXC: begin
				k = slot_of(exc_mode);
				if (k >= 0) begin
					model_spsr[k] = model_cpsr;
					model_cpsr.mode = exc_mode;
					model_cpsr.mask.i = 1'b1;
					if (exc_mode == MODE_FIQ)
						model_cpsr.mask.f = 1'b1;
				end
			end
			OP_RET: begin
				k = slot_of(model_cpsr.mode);
				if (k >= 0)
					model_cpsr = apply_write(model_spsr[k], 1'b1, 1'b1, model_cpsr);
			end
			default: ;
		endcase
	endtask

	task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
		if (act !== exp) begin
			$display("ERROR %0t %s expected 0x%h actual 0x%h", $time, name, exp, act);
			test_errors++;
		end
	endtask

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			model_cpsr = '0;
			model_cpsr.mask = 2'b11; // supervisor with IRQ and FIQ masked
			model_cpsr.mode = MODE_SVC;
			for (int k = 0; k < `PSR_BANKS; k++)
				model_spsr[k] = '0;
		end else begin
			step_model();
		end
	end

	// outputs settle half a cycle after the edge, inputs one ns after it
	always @(negedge clk) begin
		psr_state src;
		int       k;
		if (rst_n) begin
			k = slot_of(model_cpsr.mode);
			src = model_cpsr;
			if (saved)
				src = (k >= 0) ? model_spsr[k] : '0;
			check_value("flags", 32'(model_cpsr.flags), 32'(flags));
			check_value("mask", 32'(model_cpsr.mask), 32'(mask));
			check_value("mode", 32'(model_cpsr.mode), 32'(mode));
			check_value("psr_rd", {src.flags, 19'b0, 1'b1, src.mask, 1'b0, src.mode}, psr_rd);
		end
	end

	task automatic finish_test(string name, logic [4:0] exp_mode);
		check_value("mode", 32'(exp_mode), 32'(mode));
		tests_run++;
		if (test_errors == 0) begin
			$display("PASS %s", name);
		end else begin
			tests_failed++;
			$display("FAIL %s with %0d mismatches", name, test_errors);
		end
		test_errors = 0;
	endtask

endmodule

/* verif/psr_unit_chk.sv */
`timescale 1ns/100ps
`include "psr_params.svh"

module psr_unit_chk
	import psr_arch_pkg::*;
(
	input logic       clk,
	input logic       rst_n,
	input psr_mode    mode,
	input psr_intmask mask,
	input psr_state   spsr_bank [`PSR_BANKS]
);

	psr_state              prev_bank [`PSR_BANKS];
	logic [`PSR_BANKS-1:0] slot_changed;
	int                    assert_fails = 0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < `PSR_BANKS; k++)
				prev_bank[k] <= '0;
		end else begin
			for (int k = 0; k < `PSR_BANKS; k++)
				prev_bank[k] <= spsr_bank[k];
		end
	end

	always_comb begin
		for (int k = 0; k < `PSR_BANKS; k++)
			slot_changed[k] = (spsr_bank[k] != prev_bank[k]);
	end

	a_one_slot: assert property (@(posedge clk) disable iff (!rst_n) $countones(slot_changed) <= 1)
		else begin
			$error("more than one SPSR slot changed in one cycle");
			assert_fails++;
		end

	a_mode_valid: assert property (@(posedge clk) disable iff (!rst_n)
		mode inside {MODE_USR, MODE_FIQ, MODE_IRQ, MODE_SVC, MODE_ABT, MODE_UND, MODE_SYS})
		else begin
			$error("CPSR mode holds an encoding that is not a processor mode");
			assert_fails++;
		end

	// only user code staying in user mode is covered, exception entry may still mask
	a_usr_mask: assert property (@(posedge clk) disable iff (!rst_n)
		(mode == MODE_USR) ##1 (mode == MODE_USR) |-> $stable(mask))
		else begin
			$error("interrupt mask changed while the core stayed in user mode");
			assert_fails++;
		end

endmodule

/* verif/psr_unit_tb.sv */
`timescale 1ns/100ps

module psr_unit_tb
	import psr_arch_pkg::*, psr_ctrl_pkg::*;
;

	localparam int CLK_PERIOD = 8;
	localparam int RST_CYCLES = 16;

	typedef struct {
		string      name;
		psr_op      op;
		logic       saved;
		logic       wr_flags;
		logic       wr_control;
		logic       v_valid;
		logic [4:0] wr_mode;  // mode field placed into psr_wr
		logic [1:0] wr_mask;
		logic [4:0] exc_mode;
		logic [4:0] exp_mode; // CPSR mode once the row has taken effect
	} step_t;

	logic       clk;
	logic       rst_n;
	psr_op      op;
	logic       saved;
	logic       wr_flags;
	logic       wr_control;
	logic       alu_v_valid;
	psr_flags   alu_flags;
	word        psr_wr;
	psr_mode    exc_mode;
	psr_flags   flags;
	psr_intmask mask;
	psr_mode    mode;
	word        psr_rd;
	int         tests_run;
	int         tests_failed;
	step_t      steps [$];
	logic       table_ready = 1'b0;
	logic [31:0] lfsr = 32'h6caa9059;

	psr_unit psr_unit_i (.*);

	psr_scoreboard sb_i (.*);

	bind psr_unit psr_unit_chk chk_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.mode      (mode),
		.mask      (mask),
		.spsr_bank (spsr_bank)
	);

	// taps 32, 22, 2 and 1 with one step per returned bit
	function automatic logic [31:0] random_bits(int n);
		logic [31:0] bits;
		bits = '0;
		for (int b = 0; b < n; b++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			bits = {bits[30:0], lfsr[0]};
		end
		return bits;
	endfunction

	function automatic void add_row(string name, psr_op o, logic sv, logic wf, logic wc,
		logic vv, logic [4:0] wm, logic [1:0] wk, logic [4:0] em, logic [4:0] xm);
		step_t s;
		s = '{name, o, sv, wf, wc, vv, wm, wk, em, xm};
		steps.push_back(s);
	endfunction

	function automatic void build_table();
		add_row("reset_state", OP_NONE, 0, 0, 0, 0, MODE_SVC, 2'b00, MODE_SVC, MODE_SVC);
		add_row("reset_state", OP_NONE, 1, 0, 0, 0, MODE_SVC, 2'b00, MODE_SVC, MODE_SVC);
		add_row("flags_update", OP_FLAGS, 0, 0, 0, 1, MODE_SVC, 2'b00, MODE_SVC, MODE_SVC);
		add_row("flags_update", OP_FLAGS, 0, 0, 0, 0, MODE_SVC, 2'b00, MODE_SVC, MODE_SVC);
		add_row("flags_update", OP_FLAGS, 0, 0, 0, 0, MODE_SVC, 2'b00, MODE_SVC, MODE_SVC);
		add_row("ret_zero_slot", OP_RET, 0, 0, 0, 0, MODE_SVC, 2'b00, MODE_SVC, MODE_SVC);
		add_row("msr_cpsr", OP_MSR, 0, 0, 0, 0, MODE_SYS, 2'b00, MODE_SVC, MODE_SVC);
		add_row("msr_cpsr", OP_MSR, 0, 1, 0, 0, MODE_ABT, 2'b11, MODE_SVC, MODE_SVC);
		add_row("msr_cpsr", OP_MSR, 0, 0, 1, 0, 5'b00101, 2'b01, MODE_SVC, MODE_SVC);
		add_row("msr_cpsr", OP_MSR, 0, 1, 1, 0, MODE_IRQ, 2'b10, MODE_SVC, MODE_IRQ);
		add_row("msr_cpsr", OP_MSR, 0, 1, 1, 0, MODE_SYS, 2'b00, MODE_SVC, MODE_SYS);
		add_row("msr_user", OP_MSR, 0, 1, 1, 0, MODE_USR, 2'b11, MODE_SVC, MODE_USR);
		add_row("msr_user", OP_MSR, 0, 1, 1, 0, MODE_SVC, 2'b00, MODE_SVC, MODE_USR);
		add_row("exc_entry", OP_EXC, 0, 0, 0, 0, MODE_SVC, 2'b00, MODE_IRQ, MODE_IRQ);
		add_row("exc_entry", OP_NONE, 1, 0, 0, 0, MODE_SVC, 2'b00, MODE_SVC, MODE_IRQ);
		add_row("exc_entry", OP_MSR, 0, 0, 1, 0, MODE_SVC, 2'b00, MODE_SVC, MODE_SVC);
		add_row("exc_entry", OP_EXC, 0, 0, 0, 0, MODE_SVC, 2'b00, MODE_UND, MODE_UND);
		add_row("exc_entry", OP_NONE, 1, 0, 0, 0, MODE_SVC, 2'b00, MODE_SVC, MODE_UND);
		add_row("exc_entry", OP_MSR, 0, 0, 1, 0, MODE_ABT, 2'b00, MODE_SVC, MODE_ABT);
		add_row("exc_entry", OP_EXC, 0, 0, 0, 0, MODE_SVC, 2'b00, MODE_FIQ, MODE_FIQ);
		add_row("exc_entry", OP_NONE, 1, 0, 0, 0, MODE_SVC, 2'b00, MODE_SVC, MODE_FIQ);
		add_row("exc_entry", OP_EXC, 0, 0, 0, 0, MODE_SVC, 2'b00, MODE_ABT, MODE_ABT);
		add_row("exc_entry", OP_NONE, 1, 0, 0, 0, MODE_SVC, 2'b00, MODE_SVC, MODE_ABT);
		add_row("exc_entry", OP_EXC, 0, 0, 0, 0, MODE_SVC, 2'b00, MODE_SVC, MODE_SVC);
		add_row("exc_entry", OP_NONE, 1, 0, 0, 0, MODE_SVC, 2'b00, MODE_SVC, MODE_SVC);
		add_row("exc_entry", OP_EXC, 0, 0, 0, 0, MODE_SVC, 2'b00, MODE_USR, MODE_SVC);
		add_row("exc_entry", OP_EXC, 0, 0, 0, 0, MODE_SVC, 2'b00, MODE_SYS, MODE_SVC);
		add_row("spsr_return", OP_MSR, 1, 1, 1, 0, MODE_UND, 2'b01, MODE_SVC, MODE_SVC);
		add_row("spsr_return", OP_NONE, 1, 0, 0, 0, MODE_SVC, 2'b00, MODE_SVC, MODE_SVC);
		add_row("spsr_return", OP_RET, 0, 0, 0, 0, MODE_SVC, 2'b00, MODE_SVC, MODE_UND);
		add_row("spsr_return", OP_MSR, 1, 0, 1, 0, MODE_IRQ, 2'b11, MODE_SVC, MODE_UND);
		add_row("spsr_return", OP_RET, 0, 0, 0, 0, MODE_SVC, 2'b00, MODE_SVC, MODE_IRQ);
		add_row("sys_saved", OP_MSR, 0, 1, 1, 0, MODE_SYS, 2'b00, MODE_SVC, MODE_SYS);
		add_row("sys_saved", OP_MSR, 1, 1, 1, 0, MODE_FIQ, 2'b11, MODE_SVC, MODE_SYS);
		add_row("sys_saved", OP_NONE, 1, 0, 0, 0, MODE_SVC, 2'b00, MODE_SVC, MODE_SYS);
		add_row("sys_saved", OP_RET, 0, 0, 0, 0, MODE_SVC, 2'b00, MODE_SVC, MODE_SYS);
		add_row("sys_saved", OP_MSR, 0, 0, 1, 0, MODE_FIQ, 2'b01, MODE_SVC, MODE_FIQ);
		add_row("sys_saved", OP_NONE, 1, 0, 0, 0, MODE_SVC, 2'b00, MODE_SVC, MODE_FIQ);
	endfunction

	task automatic drive_step(step_t s);
		word w;
		w = random_bits(32); // reserved and T bits stay random on purpose
		w[7:6] = s.wr_mask;
		w[4:0] = s.wr_mode;
		op = s.op;
		saved = s.saved;
		wr_flags = s.wr_flags;
		wr_control = s.wr_control;
		alu_v_valid = s.v_valid;
		alu_flags = psr_flags'(random_bits(4));
		psr_wr = w;
		exc_mode = psr_mode'(s.exc_mode);
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		wait (table_ready);
		#(steps.size() * CLK_PERIOD * 4 + RST_CYCLES * CLK_PERIOD);
		$display("timeout: the stimulus table did not finish in the expected time");
		$display("Test failed");
		$finish;
	end

	initial begin
		int n_tests;
		int asserts;

		n_tests = 0;
		rst_n = 1'b0;
		op = OP_NONE;
		saved = 1'b0;
		wr_flags = 1'b0;
		wr_control = 1'b0;
		alu_v_valid = 1'b0;
		alu_flags = '0;
		psr_wr = '0;
		exc_mode = MODE_SVC;
		build_table();
		table_ready = 1'b1;

		repeat (RST_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1;

		for (int i = 0; i < steps.size(); i++) begin
			@(posedge clk);
			#1 drive_step(steps[i]);
			if (i == steps.size() - 1 || steps[i + 1].name != steps[i].name) begin
				@(posedge clk);
				#1 op = OP_NONE; // one quiet cycle so the last row can be seen
				@(negedge clk);
				#1 sb_i.finish_test(steps[i].name, steps[i].exp_mode);
				n_tests++;
			end
		end

		asserts = psr_unit_i.chk_i.assert_fails;
		$display("%0d tests run, %0d failed, %0d assertion failures",
			tests_run, tests_failed, asserts);
		if (tests_failed == 0 && tests_run == n_tests && asserts == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+hw
hw/psr_arch_pkg.sv
hw/psr_ctrl_pkg.sv
hw/psr_write_unit.sv
hw/spsr_slot.sv
hw/psr_read_mux.sv
hw/psr_unit.sv
verif/psr_unit_chk.sv
verif/psr_scoreboard.sv
verif/psr_unit_tb.sv
